// File: run_sim.sh
#!/bin/sh
# Build and run the dual-clock FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f sim.f --top-module fifo_async_tb -o fifo_async_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/fifo_async_sim > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
exit 0

// File: sim.f
+incdir+verilog
verilog/fifo_ptr_pkg.sv
verilog/fifo_data_pkg.sv
verilog/fifo_threshold_regs.sv
verilog/fifo_full_block.sv
verilog/fifo_empty_block.sv
verilog/fifo_gray_sync.sv
verilog/fifo_mem.sv
verilog/fifo_async_top.sv
testbench/fifo_async_tb.sv

// File: testbench/fifo_async_tb.sv
`timescale 1ns/1ps
`include "fifo_defs.svh"

module fifo_async_tb;
  import fifo_ptr_pkg::*;
  import fifo_data_pkg::*;

  localparam int WR_HALF = 2;
  localparam int RD_HALF = 3;
  localparam int NUM_ROWS = 14;
  localparam int SETTLE_CYCLES = 12;

  // One step of the test sequence
  typedef struct {
    string name;
    int    threshold;
    int    writes;
    int    reads;
    bit    full;
    bit    prog_full;
    bit    empty;
  } row_t;

  logic        wr_clk;
  logic        rd_clk;
  logic        reset;
  logic        wr_write;
  word_t       wr_data;
  cfg_req_t    cfg;
  logic        rd_read;
  wr_status_t  wr_status;
  logic        rd_empty;
  word_t       rd_data;
  logic        rd_valid;

  row_t        rows[$];
  word_t       expected_words[$];
  int          model_level;
  int          level_start;
  string       cur_test;
  ptr_t        rd_ptr_before;

  fifo_async_top u_dut (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .reset     (reset),
    .wr_write  (wr_write),
    .wr_data   (wr_data),
    .cfg       (cfg),
    .rd_read   (rd_read),
    .wr_status (wr_status),
    .rd_empty  (rd_empty),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

  // ##########################################################################
  // Clocks and watchdog

  initial
  begin
    wr_clk = 1'b0;
    forever #WR_HALF wr_clk = ~wr_clk;
  end

  initial
  begin
    rd_clk = 1'b0;
    forever #RD_HALF rd_clk = ~rd_clk;
  end

  // Budget of 200 write cycles per row
  initial
  begin
    #(NUM_ROWS * 200 * 2 * WR_HALF);
    $display("Watchdog expired before the test sequence completed");
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped by watchdog");
  end

  // ##########################################################################
  // Helpers

  task automatic check_value(string what, int expected, int actual);
    assert (actual == expected)
    else
    begin
      $display("Mismatch in %s: %s expected 'h%0h actual 'h%0h",
               cur_test, what, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopping at first error");
    end
  endtask

  task automatic add_row(string name, int thr, int nw, int nr, bit f, bit pf, bit e);
    row_t r;
    r.name      = name;
    r.threshold = thr;
    r.writes    = nw;
    r.reads     = nr;
    r.full      = f;
    r.prog_full = pf;
    r.empty     = e;
    rows.push_back(r);
  endtask

  // Config strobe held for one wr_clk cycle
  task automatic program_threshold(int thr);
    @(negedge wr_clk);
    cfg.write     = 1'b1;
    cfg.threshold = level_t'(thr);
    @(negedge wr_clk);
    cfg.write     = 1'b0;
  endtask

  // Model accepts only while below depth
  // Waits out a stale full flag when the model still has room
  task automatic issue_writes(int count);
    for (int i = 0; i < count; i++)
    begin
      @(negedge wr_clk);
      wr_write = 1'b0;
      while (model_level < `FIFO_DEPTH && wr_status.full)
        @(negedge wr_clk);
      wr_data  = word_t'($urandom);
      wr_write = 1'b1;
      if (model_level < `FIFO_DEPTH)
      begin
        expected_words.push_back(wr_data);
        model_level++;
      end
    end
    @(negedge wr_clk);
    wr_write = 1'b0;
  endtask

  // Reads on an empty model are expected to be dropped
  task automatic issue_reads(int count);
    for (int i = 0; i < count; i++)
    begin
      @(negedge rd_clk);
      rd_read = 1'b0;
      // Write pointer may still be crossing over
      while (model_level > 0 && rd_empty)
        @(negedge rd_clk);
      rd_read = 1'b1;
      if (model_level > 0)
        model_level--;
    end
    @(negedge rd_clk);
    rd_read = 1'b0;
  endtask

  // Every valid word must match the scoreboard queue head
  always @(negedge rd_clk)
  begin
    if (!reset && rd_valid)
    begin
      assert (expected_words.size() > 0)
      else
      begin
        $display("Read data came out in %s while no word was pending", cur_test);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopping at first error");
      end
      check_value("read data", int'(expected_words[0]), int'(rd_data));
      void'(expected_words.pop_front());
    end
  end

  // ##########################################################################
  // Stimulus

  initial
  begin
    void'($urandom(39939));
    reset       = 1'b1;
    wr_write    = 1'b0;
    wr_data     = '0;
    cfg         = '0;
    rd_read     = 1'b0;
    model_level = 0;
    cur_test    = "reset";

    // name, threshold, writes, reads, full, prog_full, empty
    add_row("reset_state",     0,  0,  0, 1'b0, 1'b0, 1'b1);
    add_row("write5_read5",    0,  5,  5, 1'b0, 1'b0, 1'b1);
    add_row("overfill20",      0, 20,  0, 1'b1, 1'b1, 1'b0);
    add_row("drain16",         0,  0, 16, 1'b0, 1'b0, 1'b1);
    add_row("level11",         0, 11,  0, 1'b0, 1'b0, 1'b0);
    add_row("level12",         0,  1,  0, 1'b0, 1'b1, 1'b0);
    add_row("thr6_level6",     6,  0,  6, 1'b0, 1'b1, 1'b0);
    add_row("thr6_level5",     0,  0,  1, 1'b0, 1'b0, 1'b0);
    add_row("drain5",          0,  0,  5, 1'b0, 1'b0, 1'b1);
    add_row("read_empty",      0,  0,  3, 1'b0, 1'b0, 1'b1);
    add_row("write1_read1",    0,  1,  1, 1'b0, 1'b0, 1'b1);
    add_row("fill16",          0, 16,  0, 1'b1, 1'b1, 1'b0);
    add_row("read1_from_full", 0,  0,  1, 1'b0, 1'b1, 1'b0);
    add_row("drain_all",       0,  0, 15, 1'b0, 1'b0, 1'b1);

    repeat (16) @(posedge wr_clk);
    @(negedge wr_clk);
    reset = 1'b0;

    foreach (rows[r])
    begin
      cur_test    = rows[r].name;
      level_start = model_level;
      if (rows[r].threshold != 0)
        program_threshold(rows[r].threshold);
      rd_ptr_before = u_dut.u_empty_block.rd_gray_pointer;
      issue_writes(rows[r].writes);
      issue_reads(rows[r].reads);

      // Let both synchronizers and flag registers catch up
      repeat (SETTLE_CYCLES) @(posedge rd_clk);
      @(negedge wr_clk);

      check_value("full", int'(rows[r].full), int'(wr_status.full));
      check_value("prog_full", int'(rows[r].prog_full), int'(wr_status.prog_full));
      check_value("empty", int'(rows[r].empty), int'(rd_empty));
      check_value("rd_valid", 0, int'(rd_valid));
      check_value("pending words", model_level, expected_words.size());

      // Reads on an empty FIFO must not move the read pointer
      if (rows[r].writes == 0 && level_start == 0)
        check_value("read pointer", int'(rd_ptr_before),
                    int'(u_dut.u_empty_block.rd_gray_pointer));
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog/fifo_async_top.sv
`timescale 1ns/1ps

module fifo_async_top
(
  input  logic                     wr_clk,
  input  logic                     rd_clk,
  input  logic                     reset,
  input  logic                     wr_write,
  input  fifo_data_pkg::word_t     wr_data,
  input  fifo_data_pkg::cfg_req_t  cfg,
  input  logic                     rd_read,
  output fifo_ptr_pkg::wr_status_t wr_status,
  output logic                     rd_empty,
  output fifo_data_pkg::word_t     rd_data,
  output logic                     rd_valid
);
  import fifo_ptr_pkg::*;

  // Write domain
  level_t prog_threshold;
  logic   mem_write;
  addr_t  wr_addr;
  ptr_t   wr_gray_pointer;
  ptr_t   wr_rd_gray_pointer;

  // Read domain
  logic   mem_read;
  addr_t  rd_addr;
  ptr_t   rd_gray_pointer;
  ptr_t   rd_wr_gray_pointer;

  // ########################################################################
  // Write side

  fifo_threshold_regs u_threshold_regs (
    .wr_clk         (wr_clk),
    .reset          (reset),
    .cfg            (cfg),
    .prog_threshold (prog_threshold)
  );

  fifo_full_block u_full_block (
    .wr_clk             (wr_clk),
    .reset              (reset),
    .wr_write           (wr_write),
    .prog_threshold     (prog_threshold),
    .wr_rd_gray_pointer (wr_rd_gray_pointer),
    .mem_write          (mem_write),
    .wr_addr            (wr_addr),
    .wr_gray_pointer    (wr_gray_pointer),
    .wr_status          (wr_status)
  );

  // Read pointer into wr_clk
  fifo_gray_sync u_rd_to_wr_sync (
    .clk      (wr_clk),
    .reset    (reset),
    .gray_in  (rd_gray_pointer),
    .gray_out (wr_rd_gray_pointer)
  );

  // ########################################################################
  // Read side

  // Write pointer into rd_clk
  fifo_gray_sync u_wr_to_rd_sync (
    .clk      (rd_clk),
    .reset    (reset),
    .gray_in  (wr_gray_pointer),
    .gray_out (rd_wr_gray_pointer)
  );

  fifo_empty_block u_empty_block (
    .rd_clk             (rd_clk),
    .reset              (reset),
    .rd_read            (rd_read),
    .rd_wr_gray_pointer (rd_wr_gray_pointer),
    .mem_read           (mem_read),
    .rd_addr            (rd_addr),
    .rd_gray_pointer    (rd_gray_pointer),
    .rd_empty           (rd_empty)
  );

  // Storage spans both clocks
  fifo_mem u_mem (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .reset     (reset),
    .mem_write (mem_write),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .mem_read  (mem_read),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

endmodule

// File: verilog/fifo_data_pkg.sv
`include "fifo_defs.svh"

package fifo_data_pkg;

  // One payload word
  typedef logic [`FIFO_DW-1:0] word_t;

  // Threshold update, single-cycle strobe plus value
  // Lives in the write clock domain
  typedef struct packed {
    logic                 write;
    fifo_ptr_pkg::level_t threshold;
  } cfg_req_t;

endpackage

// File: verilog/fifo_defs.svh
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// Address bits into the storage array
`define FIFO_AW 4

// Entries in the array, one per address
`define FIFO_DEPTH (1 << `FIFO_AW)

// Payload width of one word
`define FIFO_DW 16

// Almost-full level loaded at reset
// Must stay within 1 to FIFO_DEPTH
`define FIFO_PROGFULL_RESET 12

`endif

// File: verilog/fifo_empty_block.sv
`timescale 1ns/1ps
`include "fifo_defs.svh"

module fifo_empty_block
(
  input  logic                rd_clk,
  input  logic                reset,
  input  logic                rd_read,
  input  fifo_ptr_pkg::ptr_t  rd_wr_gray_pointer,
  output logic                mem_read,
  output fifo_ptr_pkg::addr_t rd_addr,
  output fifo_ptr_pkg::ptr_t  rd_gray_pointer,
  output logic                rd_empty
);
  import fifo_ptr_pkg::*;

  ptr_t rd_binary_pointer;
  ptr_t rd_binary_next;
  ptr_t rd_gray_next;
  logic empty_next;

  // Reads while empty are dropped here
  assign mem_read = rd_read & ~rd_empty;

  assign rd_binary_next = rd_binary_pointer + ptr_t'(mem_read);
  assign rd_gray_next   = (rd_binary_next >> 1) ^ rd_binary_next;

  // Pointer pair, only moves on an accepted read
  always_ff @(posedge rd_clk or posedge reset)
  begin
    if (reset)
    begin
      rd_binary_pointer <= '0;
      rd_gray_pointer   <= '0;
    end
    else
    begin
      rd_binary_pointer <= rd_binary_next;
      rd_gray_pointer   <= rd_gray_next;
    end
  end

  assign rd_addr = rd_binary_pointer[`FIFO_AW-1:0];

  // Empty when caught up with the synced write pointer
  assign empty_next = (rd_gray_next == rd_wr_gray_pointer);

  // Starts empty out of reset
  always_ff @(posedge rd_clk or posedge reset)
  begin
    if (reset)
      rd_empty <= 1'b1;
    else
      rd_empty <= empty_next;
  end

endmodule

// File: verilog/fifo_full_block.sv
`timescale 1ns/1ps
`include "fifo_defs.svh"

module fifo_full_block
(
  input  logic                     wr_clk,
  input  logic                     reset,
  input  logic                     wr_write,
  input  fifo_ptr_pkg::level_t     prog_threshold,
  input  fifo_ptr_pkg::ptr_t       wr_rd_gray_pointer,
  output logic                     mem_write,
  output fifo_ptr_pkg::addr_t      wr_addr,
  output fifo_ptr_pkg::ptr_t       wr_gray_pointer,
  output fifo_ptr_pkg::wr_status_t wr_status
);
  import fifo_ptr_pkg::*;

  ptr_t   wr_binary_pointer;
  ptr_t   wr_binary_next;
  ptr_t   wr_gray_next;
  ptr_t   wr_rd_binary_pointer;
  level_t wr_level_next;
  logic   full_next;
  logic   prog_full_next;

  // ########################################################################
  // Write pointers

  // Writes while full are dropped here
  assign mem_write = wr_write & ~wr_status.full;

  assign wr_binary_next = wr_binary_pointer + ptr_t'(mem_write);

  // Binary to Gray, one bit changes per step
  assign wr_gray_next = (wr_binary_next >> 1) ^ wr_binary_next;

  always_ff @(posedge wr_clk or posedge reset)
  begin
    if (reset)
    begin
      wr_binary_pointer <= '0;
      wr_gray_pointer   <= '0;
    end
    else
    begin
      wr_binary_pointer <= wr_binary_next;
      wr_gray_pointer   <= wr_gray_next;
    end
  end

  // Lap bit dropped for the array index
  assign wr_addr = wr_binary_pointer[`FIFO_AW-1:0];

  // ########################################################################
  // Flags

  // Full when one lap ahead
  // In Gray code that means the top two bits differ and the rest match
  assign full_next = (wr_gray_next == {~wr_rd_gray_pointer[`FIFO_AW:`FIFO_AW-1],
                                       wr_rd_gray_pointer[`FIFO_AW-2:0]});

  // Gray to binary on the synced read pointer
  // Each bit is the XOR of itself and every bit above
  always_comb
  begin
    for (int i = 0; i <= `FIFO_AW; i++)
      wr_rd_binary_pointer[i] = ^(wr_rd_gray_pointer >> i);
  end

  // Wraps modulo 2*depth, so the difference is the true level
  assign wr_level_next  = wr_binary_next - wr_rd_binary_pointer;
  assign prog_full_next = (wr_level_next >= prog_threshold);

  // Both flags one cycle behind the accepted write
  always_ff @(posedge wr_clk or posedge reset)
  begin
    if (reset)
      wr_status <= '0;
    else
    begin
      wr_status.full      <= full_next;
      wr_status.prog_full <= prog_full_next;
    end
  end

endmodule

// File: verilog/fifo_gray_sync.sv
`timescale 1ns/1ps

module fifo_gray_sync
(
  input  logic               clk,
  input  logic               reset,
  input  fifo_ptr_pkg::ptr_t gray_in,
  output fifo_ptr_pkg::ptr_t gray_out
);
  import fifo_ptr_pkg::*;

  // First stage may go metastable
  ptr_t gray_meta;

  // Gray input, so at most one bit is in flight per sample
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      gray_meta <= '0;
      gray_out  <= '0;
    end
    else
    begin
      gray_meta <= gray_in;
      gray_out  <= gray_meta;
    end
  end

endmodule

// File: verilog/fifo_mem.sv
`timescale 1ns/1ps
`include "fifo_defs.svh"

module fifo_mem
(
  input  logic                 wr_clk,
  input  logic                 rd_clk,
  input  logic                 reset,
  input  logic                 mem_write,
  input  fifo_ptr_pkg::addr_t  wr_addr,
  input  fifo_data_pkg::word_t wr_data,
  input  logic                 mem_read,
  input  fifo_ptr_pkg::addr_t  rd_addr,
  output fifo_data_pkg::word_t rd_data,
  output logic                 rd_valid
);
  import fifo_data_pkg::*;

  word_t mem_array [`FIFO_DEPTH];

  // Write port, wr_clk domain
  always_ff @(posedge wr_clk)
  begin
    if (mem_write)
      mem_array[wr_addr] <= wr_data;
  end

  // Registered read port, data lands with rd_valid
  always_ff @(posedge rd_clk)
  begin
    if (mem_read)
      rd_data <= mem_array[rd_addr];
  end

  // One cycle after each accepted read
  always_ff @(posedge rd_clk or posedge reset)
  begin
    if (reset)
      rd_valid <= 1'b0;
    else
      rd_valid <= mem_read;
  end

endmodule

// File: verilog/fifo_ptr_pkg.sv
`include "fifo_defs.svh"

package fifo_ptr_pkg;

  // Binary or Gray pointer
  // Extra top bit separates one lap of the array from the next
  typedef logic [`FIFO_AW:0] ptr_t;

  // Index into the storage array
  typedef logic [`FIFO_AW-1:0] addr_t;

  // Fill level or threshold, 0 up to FIFO_DEPTH
  typedef logic [`FIFO_AW:0] level_t;

  // Registered write-side flags
  typedef struct packed {
    logic full;
    logic prog_full;
  } wr_status_t;

endpackage

// File: verilog/fifo_threshold_regs.sv
`timescale 1ns/1ps
`include "fifo_defs.svh"

module fifo_threshold_regs
(
  input  logic                   wr_clk,
  input  logic                   reset,
  input  fifo_data_pkg::cfg_req_t cfg,
  output fifo_ptr_pkg::level_t   prog_threshold
);
  import fifo_ptr_pkg::*;

  level_t load_value;

  // Clamp to 1..FIFO_DEPTH
  // Zero would keep prog_full set even when empty
  always_comb
  begin
    if (cfg.threshold == '0)
      load_value = level_t'(1);
    else if (cfg.threshold > level_t'(`FIFO_DEPTH))
      load_value = level_t'(`FIFO_DEPTH);
    else
      load_value = cfg.threshold;
  end

  // Threshold register, new value seen by the flag one cycle later
  always_ff @(posedge wr_clk or posedge reset)
  begin
    if (reset)
      prog_threshold <= level_t'(`FIFO_PROGFULL_RESET);
    else if (cfg.write)
      prog_threshold <= load_value;
  end

endmodule
